/* rv32i_types.sv */
package rv32i_types;

    typedef logic [31:0] word_t;

    // physical tag width, carried inside the packed structs
    localparam int PHYS_REG_BITS = 6;

    typedef logic [PHYS_REG_BITS-1:0] phys_reg_t;
    typedef logic [4:0]               arch_reg_t;

    // functional unit select, zero means an idle slot
    typedef logic [1:0] fu_sel_t;

    localparam fu_sel_t FU_NONE = 2'd0;
    localparam fu_sel_t FU_ALU  = 2'd1;
    localparam fu_sel_t FU_MUL  = 2'd2;
    localparam fu_sel_t FU_DIV  = 2'd3;

    typedef logic [2:0] alu_op_t;

    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_XOR = 3'd4;
    localparam alu_op_t ALU_SLT = 3'd5;
    localparam alu_op_t ALU_SLL = 3'd6;
    localparam alu_op_t ALU_SRL = 3'd7;

    // high selects mulhu for the multiplier and rem for the divider
    typedef struct packed {
        logic      valid;
        fu_sel_t   fu;
        alu_op_t   alu_op;
        logic      high;
        logic      use_imm;
        word_t     imm;
        phys_reg_t rs1;
        phys_reg_t rs2;
        phys_reg_t rd;
        arch_reg_t arch_rs1;
        arch_reg_t arch_rs2;
        arch_reg_t arch_rd;
    } issue_pkt_t;

    typedef struct packed {
        logic      start;
        alu_op_t   op;
        logic      high;
        logic      use_imm;
        word_t     imm;
        phys_reg_t rd;
        arch_reg_t arch_rd;
    } fu_req_t;

    typedef struct packed {
        logic      valid;
        phys_reg_t rd;
        arch_reg_t arch_rd;
        word_t     value;
    } wb_pkt_t;

    typedef struct packed {
        logic      valid;
        phys_reg_t rd;
        word_t     value;
    } cmpl_pkt_t;

endpackage

/* issue_router.sv */
`timescale 1ns/1ps

module issue_router (
    input  rv32i_types::issue_pkt_t issue,
    output rv32i_types::fu_req_t    alu_req,
    output rv32i_types::fu_req_t    mul_req,
    output rv32i_types::fu_req_t    div_req,
    output rv32i_types::phys_reg_t  alu_src1,
    output rv32i_types::phys_reg_t  alu_src2,
    output rv32i_types::arch_reg_t  alu_arch_src1,
    output rv32i_types::arch_reg_t  alu_arch_src2,
    output rv32i_types::phys_reg_t  mul_src1,
    output rv32i_types::phys_reg_t  mul_src2,
    output rv32i_types::arch_reg_t  mul_arch_src1,
    output rv32i_types::arch_reg_t  mul_arch_src2,
    output rv32i_types::phys_reg_t  div_src1,
    output rv32i_types::phys_reg_t  div_src2,
    output rv32i_types::arch_reg_t  div_arch_src1,
    output rv32i_types::arch_reg_t  div_arch_src2
);
    import rv32i_types::*;

    fu_req_t base_req;

    // operation fields go to every unit, only the start strobe is steered
    always_comb begin
        base_req.start   = 1'b0;
        base_req.op      = issue.alu_op;
        base_req.high    = issue.high;
        base_req.use_imm = issue.use_imm;
        base_req.imm     = issue.imm;
        base_req.rd      = issue.rd;
        base_req.arch_rd = issue.arch_rd;
    end

    always_comb begin
        alu_req = base_req;
        mul_req = base_req;
        div_req = base_req;
        // idle read ports sit on tag 0 and read zero
        alu_src1      = '0;
        alu_src2      = '0;
        alu_arch_src1 = '0;
        alu_arch_src2 = '0;
        mul_src1      = '0;
        mul_src2      = '0;
        mul_arch_src1 = '0;
        mul_arch_src2 = '0;
        div_src1      = '0;
        div_src2      = '0;
        div_arch_src1 = '0;
        div_arch_src2 = '0;
        if (issue.valid) begin
            case (issue.fu)
                FU_ALU: begin
                    alu_req.start = 1'b1;
                    alu_src1      = issue.rs1;
                    alu_src2      = issue.rs2;
                    alu_arch_src1 = issue.arch_rs1;
                    alu_arch_src2 = issue.arch_rs2;
                end
                FU_MUL: begin
                    mul_req.start = 1'b1;
                    mul_src1      = issue.rs1;
                    mul_src2      = issue.rs2;
                    mul_arch_src1 = issue.arch_rs1;
                    mul_arch_src2 = issue.arch_rs2;
                end
                FU_DIV: begin
                    div_req.start = 1'b1;
                    div_src1      = issue.rs1;
                    div_src2      = issue.rs2;
                    div_arch_src1 = issue.arch_rs1;
                    div_arch_src2 = issue.arch_rs2;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

/* phys_regfile.sv */
`timescale 1ns/1ps

module phys_regfile (
    input  logic                   clk,
    input  logic                   rst,
    input  rv32i_types::cmpl_pkt_t wr_alu,
    input  rv32i_types::cmpl_pkt_t wr_mul,
    input  rv32i_types::cmpl_pkt_t wr_div,
    input  rv32i_types::phys_reg_t alu_src1,
    input  rv32i_types::phys_reg_t alu_src2,
    input  rv32i_types::arch_reg_t alu_arch_src1,
    input  rv32i_types::arch_reg_t alu_arch_src2,
    input  rv32i_types::phys_reg_t mul_src1,
    input  rv32i_types::phys_reg_t mul_src2,
    input  rv32i_types::arch_reg_t mul_arch_src1,
    input  rv32i_types::arch_reg_t mul_arch_src2,
    input  rv32i_types::phys_reg_t div_src1,
    input  rv32i_types::phys_reg_t div_src2,
    input  rv32i_types::arch_reg_t div_arch_src1,
    input  rv32i_types::arch_reg_t div_arch_src2,
    output rv32i_types::word_t     alu_val1,
    output rv32i_types::word_t     alu_val2,
    output rv32i_types::word_t     mul_val1,
    output rv32i_types::word_t     mul_val2,
    output rv32i_types::word_t     div_val1,
    output rv32i_types::word_t     div_val2
);
    import rv32i_types::*;

    localparam int NUM_REGS     = 2 ** PHYS_REG_BITS;
    localparam int NUM_WR_PORTS = 3;

    word_t     regs [NUM_REGS];
    cmpl_pkt_t wr_ports [NUM_WR_PORTS];

    // zero for arch x0 or physical tag 0
    function automatic word_t read_port(phys_reg_t tag, arch_reg_t arch);
        word_t val;
        val = regs[tag];
        if (arch == '0 || tag == '0) begin
            val = '0;
        end
        return val;
    endfunction

    always_comb begin
        wr_ports[0] = wr_alu;
        wr_ports[1] = wr_mul;
        wr_ports[2] = wr_div;
    end

    // rename keeps the three destinations distinct, no port priority needed
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int p = 0; p < NUM_WR_PORTS; p++) begin
                if (wr_ports[p].valid && wr_ports[p].rd != '0) begin
                    regs[wr_ports[p].rd] <= wr_ports[p].value;
                end
            end
        end
    end

    // combinational reads in the issue cycle
    always_comb begin
        alu_val1 = read_port(alu_src1, alu_arch_src1);
        alu_val2 = read_port(alu_src2, alu_arch_src2);
        mul_val1 = read_port(mul_src1, mul_arch_src1);
        mul_val2 = read_port(mul_src2, mul_arch_src2);
        div_val1 = read_port(div_src1, div_arch_src1);
        div_val2 = read_port(div_src2, div_arch_src2);
    end

endmodule

/* alu_unit.sv */
`timescale 1ns/1ps

module alu_unit (
    input  rv32i_types::fu_req_t req,
    input  rv32i_types::word_t   op1,
    input  rv32i_types::word_t   op2,
    output rv32i_types::wb_pkt_t result
);
    import rv32i_types::*;

    word_t      src_b;
    logic [4:0] shamt;
    word_t      alu_out;

    // immediate replaces rs2 when selected
    assign src_b = req.use_imm ? req.imm : op2;
    assign shamt = src_b[4:0];

    always_comb begin
        case (req.op)
            ALU_ADD: alu_out = op1 + src_b;
            ALU_SUB: alu_out = op1 - src_b;
            ALU_AND: alu_out = op1 & src_b;
            ALU_OR:  alu_out = op1 | src_b;
            ALU_XOR: alu_out = op1 ^ src_b;
            ALU_SLT: begin
                // signed compare
                alu_out = {31'b0, $signed(op1) < $signed(src_b)};
            end
            ALU_SLL: alu_out = op1 << shamt;
            ALU_SRL: alu_out = op1 >> shamt;
            default: alu_out = '0;
        endcase
    end

    // result is ready in the issue cycle, writeback registers it
    always_comb begin
        result.valid   = req.start;
        result.rd      = req.rd;
        result.arch_rd = req.arch_rd;
        result.value   = alu_out;
    end

endmodule

/* mul_unit.sv */
`timescale 1ns/1ps

module mul_unit #(
    parameter int NUM_MUL_STAGES = 3
) (
    input  logic                 clk,
    input  logic                 rst,
    input  rv32i_types::fu_req_t req,
    input  rv32i_types::word_t   op1,
    input  rv32i_types::word_t   op2,
    output rv32i_types::wb_pkt_t result
);
    import rv32i_types::*;

    typedef struct packed {
        logic        high;
        phys_reg_t   rd;
        arch_reg_t   arch_rd;
        logic [63:0] prod;
    } mul_stage_t;

    logic [NUM_MUL_STAGES-1:0] valid_q;
    mul_stage_t                stage_q [NUM_MUL_STAGES];
    mul_stage_t                last;

    // valid chain, one bit per stage
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= req.start;
            for (int i = 1; i < NUM_MUL_STAGES; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    // full unsigned product in stage 0, carried unchanged afterwards
    always_ff @(posedge clk) begin
        stage_q[0].high    <= req.high;
        stage_q[0].rd      <= req.rd;
        stage_q[0].arch_rd <= req.arch_rd;
        stage_q[0].prod    <= 64'(op1) * 64'(op2);
        for (int i = 1; i < NUM_MUL_STAGES; i++) begin
            stage_q[i] <= stage_q[i-1];
        end
    end

    assign last = stage_q[NUM_MUL_STAGES-1];

    // low half for mul, high half for mulhu
    always_comb begin
        result.valid   = valid_q[NUM_MUL_STAGES-1];
        result.rd      = last.rd;
        result.arch_rd = last.arch_rd;
        result.value   = last.high ? last.prod[63:32] : last.prod[31:0];
    end

endmodule

/* div_unit.sv */
`timescale 1ns/1ps

module div_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  rv32i_types::fu_req_t req,
    input  rv32i_types::word_t   op1,
    input  rv32i_types::word_t   op2,
    output rv32i_types::wb_pkt_t result,
    output logic                 busy
);
    import rv32i_types::*;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_t;

    div_state_t  state_q;
    logic [4:0]  step_q;
    word_t       quot_q;
    word_t       rem_q;
    word_t       divisor_q;
    logic        high_q;
    phys_reg_t   rd_q;
    arch_reg_t   arch_rd_q;
    logic [32:0] rem_shift;
    logic        take;

    // next dividend bit enters the partial remainder
    assign rem_shift = {rem_q, quot_q[31]};
    assign take      = rem_shift >= {1'b0, divisor_q};

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= DIV_IDLE;
            step_q  <= '0;
        end else begin
            case (state_q)
                DIV_IDLE: begin
                    if (req.start) begin
                        state_q <= DIV_RUN;
                        step_q  <= '0;
                    end
                end
                DIV_RUN: begin
                    step_q <= step_q + 5'd1;
                    if (step_q == 5'd31) begin
                        state_q <= DIV_DONE;
                    end
                end
                default: state_q <= DIV_IDLE;
            endcase
        end
    end

    // quotient bits shift in from the bottom as dividend bits leave the top.
    // A zero divisor always subtracts, leaving all ones and rem = dividend
    always_ff @(posedge clk) begin
        if (state_q == DIV_IDLE && req.start) begin
            quot_q    <= op1;
            rem_q     <= '0;
            divisor_q <= op2;
            high_q    <= req.high;
            rd_q      <= req.rd;
            arch_rd_q <= req.arch_rd;
        end else if (state_q == DIV_RUN) begin
            quot_q <= {quot_q[30:0], take};
            rem_q  <= take ? (rem_shift[31:0] - divisor_q) : rem_shift[31:0];
        end
    end

    assign busy = (state_q != DIV_IDLE);

    always_comb begin
        result.valid   = (state_q == DIV_DONE);
        result.rd      = rd_q;
        result.arch_rd = arch_rd_q;
        result.value   = high_q ? rem_q : quot_q;
    end

endmodule

/* writeback_stage.sv */
`timescale 1ns/1ps

module writeback_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  rv32i_types::wb_pkt_t   alu_res,
    input  rv32i_types::wb_pkt_t   mul_res,
    input  rv32i_types::wb_pkt_t   div_res,
    output rv32i_types::cmpl_pkt_t cmpl_alu,
    output rv32i_types::cmpl_pkt_t cmpl_mul,
    output rv32i_types::cmpl_pkt_t cmpl_div
);
    import rv32i_types::*;

    // arch x0 destination completes normally but carries zero
    function automatic cmpl_pkt_t to_cmpl(wb_pkt_t res);
        cmpl_pkt_t pkt;
        pkt.valid = res.valid;
        pkt.rd    = res.rd;
        pkt.value = (res.arch_rd == '0) ? '0 : res.value;
        return pkt;
    endfunction

    always_ff @(posedge clk) begin
        cmpl_alu <= to_cmpl(alu_res);
        cmpl_mul <= to_cmpl(mul_res);
        cmpl_div <= to_cmpl(div_res);
        // valids clear on reset
        if (rst) begin
            cmpl_alu.valid <= 1'b0;
            cmpl_mul.valid <= 1'b0;
            cmpl_div.valid <= 1'b0;
        end
    end

endmodule

/* exec_backend_top.sv */
`timescale 1ns/1ps

module exec_backend_top #(
    parameter int NUM_MUL_STAGES = 3
) (
    input  logic                    clk,
    input  logic                    rst,
    input  rv32i_types::issue_pkt_t issue,
    output rv32i_types::cmpl_pkt_t  cmpl_alu,
    output rv32i_types::cmpl_pkt_t  cmpl_mul,
    output rv32i_types::cmpl_pkt_t  cmpl_div,
    output logic                    div_busy
);
    import rv32i_types::*;

    fu_req_t   alu_req;
    fu_req_t   mul_req;
    fu_req_t   div_req;
    phys_reg_t alu_src1;
    phys_reg_t alu_src2;
    phys_reg_t mul_src1;
    phys_reg_t mul_src2;
    phys_reg_t div_src1;
    phys_reg_t div_src2;
    arch_reg_t alu_arch_src1;
    arch_reg_t alu_arch_src2;
    arch_reg_t mul_arch_src1;
    arch_reg_t mul_arch_src2;
    arch_reg_t div_arch_src1;
    arch_reg_t div_arch_src2;
    word_t     alu_val1;
    word_t     alu_val2;
    word_t     mul_val1;
    word_t     mul_val2;
    word_t     div_val1;
    word_t     div_val2;
    wb_pkt_t   alu_res;
    wb_pkt_t   mul_res;
    wb_pkt_t   div_res;

    issue_router i_issue_router (
        .issue         (issue),
        .alu_req       (alu_req),
        .mul_req       (mul_req),
        .div_req       (div_req),
        .alu_src1      (alu_src1),
        .alu_src2      (alu_src2),
        .alu_arch_src1 (alu_arch_src1),
        .alu_arch_src2 (alu_arch_src2),
        .mul_src1      (mul_src1),
        .mul_src2      (mul_src2),
        .mul_arch_src1 (mul_arch_src1),
        .mul_arch_src2 (mul_arch_src2),
        .div_src1      (div_src1),
        .div_src2      (div_src2),
        .div_arch_src1 (div_arch_src1),
        .div_arch_src2 (div_arch_src2)
    );

    // completions feed the write ports directly
    phys_regfile i_phys_regfile (
        .clk           (clk),
        .rst           (rst),
        .wr_alu        (cmpl_alu),
        .wr_mul        (cmpl_mul),
        .wr_div        (cmpl_div),
        .alu_src1      (alu_src1),
        .alu_src2      (alu_src2),
        .alu_arch_src1 (alu_arch_src1),
        .alu_arch_src2 (alu_arch_src2),
        .mul_src1      (mul_src1),
        .mul_src2      (mul_src2),
        .mul_arch_src1 (mul_arch_src1),
        .mul_arch_src2 (mul_arch_src2),
        .div_src1      (div_src1),
        .div_src2      (div_src2),
        .div_arch_src1 (div_arch_src1),
        .div_arch_src2 (div_arch_src2),
        .alu_val1      (alu_val1),
        .alu_val2      (alu_val2),
        .mul_val1      (mul_val1),
        .mul_val2      (mul_val2),
        .div_val1      (div_val1),
        .div_val2      (div_val2)
    );

    alu_unit i_alu_unit (
        .req    (alu_req),
        .op1    (alu_val1),
        .op2    (alu_val2),
        .result (alu_res)
    );

    mul_unit #(
        .NUM_MUL_STAGES (NUM_MUL_STAGES)
    ) i_mul_unit (
        .clk    (clk),
        .rst    (rst),
        .req    (mul_req),
        .op1    (mul_val1),
        .op2    (mul_val2),
        .result (mul_res)
    );

    div_unit i_div_unit (
        .clk    (clk),
        .rst    (rst),
        .req    (div_req),
        .op1    (div_val1),
        .op2    (div_val2),
        .result (div_res),
        .busy   (div_busy)
    );

    writeback_stage i_writeback_stage (
        .clk      (clk),
        .rst      (rst),
        .alu_res  (alu_res),
        .mul_res  (mul_res),
        .div_res  (div_res),
        .cmpl_alu (cmpl_alu),
        .cmpl_mul (cmpl_mul),
        .cmpl_div (cmpl_div)
    );

endmodule

/* tb_exec_backend.sv */
`timescale 1ns/1ps

module tb_exec_backend;
    import rv32i_types::*;

    // multiplier depth at the DUT default
    localparam int MUL_STAGES = 3;
    localparam int DIV_WINDOW = 40;

    typedef struct {
        issue_pkt_t  pkt;
        int unsigned gap;
    } entry_t;

    typedef struct {
        fu_sel_t     unit;
        int unsigned cyc;
        phys_reg_t   rd;
        word_t       value;
    } pend_t;

    logic       clk;
    logic       rst;
    issue_pkt_t issue;
    cmpl_pkt_t  cmpl_alu;
    cmpl_pkt_t  cmpl_mul;
    cmpl_pkt_t  cmpl_div;
    logic       div_busy;

    word_t       model [64];
    entry_t      stim_q [$];
    pend_t       pend_q [$];
    int unsigned cyc;
    int unsigned cycle_limit;
    int unsigned errors;
    int unsigned checks;
    bit          triple_seen;

    exec_backend_top i_exec_backend_top (
        .clk      (clk),
        .rst      (rst),
        .issue    (issue),
        .cmpl_alu (cmpl_alu),
        .cmpl_mul (cmpl_mul),
        .cmpl_div (cmpl_div),
        .div_busy (div_busy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic arch_reg_t arch_of(phys_reg_t tag);
        return arch_reg_t'(tag % 31 + 1);
    endfunction

    function automatic issue_pkt_t make_pkt(fu_sel_t fu, alu_op_t op, logic high,
            logic use_imm, word_t imm, phys_reg_t rs1, arch_reg_t a1, phys_reg_t rs2,
            arch_reg_t a2, phys_reg_t rd, arch_reg_t ard);
        issue_pkt_t p;
        p.valid    = 1'b1;
        p.fu       = fu;
        p.alu_op   = op;
        p.high     = high;
        p.use_imm  = use_imm;
        p.imm      = imm;
        p.rs1      = rs1;
        p.rs2      = rs2;
        p.rd       = rd;
        p.arch_rs1 = a1;
        p.arch_rs2 = a2;
        p.arch_rd  = ard;
        return p;
    endfunction

    task automatic push_entry(issue_pkt_t p, int unsigned gap);
        entry_t e;
        e.pkt = p;
        e.gap = gap;
        stim_q.push_back(e);
    endtask

    task automatic push_alu(alu_op_t op, phys_reg_t rs1, phys_reg_t rs2, phys_reg_t rd,
            int unsigned gap);
        push_entry(make_pkt(FU_ALU, op, 1'b0, 1'b0, '0, rs1, arch_of(rs1), rs2,
                            arch_of(rs2), rd, arch_of(rd)), gap);
    endtask

    task automatic push_alu_imm(alu_op_t op, phys_reg_t rs1, word_t imm, phys_reg_t rd);
        push_entry(make_pkt(FU_ALU, op, 1'b0, 1'b1, imm, rs1, arch_of(rs1), '0, '0,
                            rd, arch_of(rd)), 0);
    endtask

    task automatic push_unit(fu_sel_t fu, logic high, phys_reg_t rs1, phys_reg_t rs2,
            phys_reg_t rd, int unsigned gap);
        push_entry(make_pkt(fu, ALU_ADD, high, 1'b0, '0, rs1, arch_of(rs1), rs2,
                            arch_of(rs2), rd, arch_of(rd)), gap);
    endtask

    task automatic build_table();
        // tags never written read zero
        push_alu(ALU_ADD, 6'd10, 6'd11, 6'd12, 0);
        for (int t = 1; t <= 8; t++) begin
            push_alu_imm(ALU_ADD, 6'd0, $urandom, phys_reg_t'(t));
        end
        push_alu_imm(ALU_ADD, 6'd0, 32'hffff_fff0, 6'd9);
        push_alu_imm(ALU_ADD, 6'd0, 32'd7, 6'd14);
        for (int op = 0; op < 8; op++) begin
            push_alu(alu_op_t'(op), 6'd1, 6'd2, phys_reg_t'(16 + op), 0);
            push_alu_imm(alu_op_t'(op), 6'd3, $urandom, phys_reg_t'(24 + op));
        end
        // slt across the sign boundary
        push_alu(ALU_SLT, 6'd9, 6'd14, 6'd32, 0);
        push_alu(ALU_SLT, 6'd14, 6'd9, 6'd33, 0);
        push_unit(FU_MUL, 1'b0, 6'd1, 6'd2, 6'd34, 0);
        push_unit(FU_MUL, 1'b1, 6'd1, 6'd2, 6'd35, 0);
        push_unit(FU_MUL, 1'b1, 6'd3, 6'd4, 6'd36, 0);
        push_unit(FU_MUL, 1'b0, 6'd9, 6'd9, 6'd37, 4);
        // tag 10 still holds zero, so 40 and 41 divide by zero
        push_unit(FU_DIV, 1'b0, 6'd1, 6'd14, 6'd38, 0);
        push_unit(FU_DIV, 1'b1, 6'd1, 6'd14, 6'd39, 0);
        push_unit(FU_DIV, 1'b0, 6'd2, 6'd10, 6'd40, 0);
        push_unit(FU_DIV, 1'b1, 6'd2, 6'd10, 6'd41, 0);
        push_unit(FU_DIV, 1'b0, 6'd14, 6'd5, 6'd42, 0);
        // x0 source on a live tag, then x0 destinations over live tags 9 and 37
        push_entry(make_pkt(FU_ALU, ALU_ADD, 1'b0, 1'b0, '0, 6'd1, 5'd0, 6'd2,
                            arch_of(6'd2), 6'd43, 5'd7), 0);
        push_entry(make_pkt(FU_ALU, ALU_ADD, 1'b0, 1'b1, 32'd123, 6'd1, arch_of(6'd1),
                            '0, '0, 6'd9, 5'd0), 0);
        push_entry(make_pkt(FU_MUL, ALU_ADD, 1'b0, 1'b0, '0, 6'd1, arch_of(6'd1), 6'd2,
                            arch_of(6'd2), 6'd37, 5'd0), 4);
        push_alu(ALU_OR, 6'd9, 6'd37, 6'd46, 0);
        push_alu_imm(ALU_ADD, 6'd38, 32'd1, 6'd47);
        // div latency 33, so these three finish on the same edge
        push_unit(FU_DIV, 1'b1, 6'd47, 6'd14, 6'd48, 29);
        push_unit(FU_MUL, 1'b0, 6'd4, 6'd5, 6'd49, 2);
        push_alu(ALU_XOR, 6'd5, 6'd6, 6'd50, 1);
        push_alu(ALU_ADD, 6'd48, 6'd49, 6'd51, 1);
        push_alu(ALU_SUB, 6'd50, 6'd51, 6'd52, 0);
    endtask

    function automatic word_t read_model(phys_reg_t tag, arch_reg_t arch);
        if (arch == '0 || tag == '0) begin
            return '0;
        end
        return model[tag];
    endfunction

    function automatic word_t expected_value(issue_pkt_t p);
        word_t       a;
        word_t       b;
        logic [63:0] prod;
        word_t       v;
        a = read_model(p.rs1, p.arch_rs1);
        b = read_model(p.rs2, p.arch_rs2);
        v = '0;
        if (p.fu == FU_ALU) begin
            if (p.use_imm) begin
                b = p.imm;
            end
            case (p.alu_op)
                ALU_ADD: v = a + b;
                ALU_SUB: v = a - b;
                ALU_AND: v = a & b;
                ALU_OR:  v = a | b;
                ALU_XOR: v = a ^ b;
                ALU_SLT: v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                ALU_SLL: v = a << b[4:0];
                default: v = a >> b[4:0];
            endcase
        end else if (p.fu == FU_MUL) begin
            prod = {32'b0, a} * {32'b0, b};
            v = p.high ? prod[63:32] : prod[31:0];
        end else if (b == '0) begin
            // RISC-V divide by zero
            v = p.high ? a : 32'hffff_ffff;
        end else begin
            v = p.high ? a % b : a / b;
        end
        if (p.arch_rd == '0) begin
            v = '0;
        end
        return v;
    endfunction

    function automatic int find_pend(fu_sel_t unit);
        for (int i = 0; i < pend_q.size(); i++) begin
            if (pend_q[i].unit == unit) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic check_unit(string name, fu_sel_t unit, cmpl_pkt_t c);
        int    idx;
        pend_t e;
        bit    late;
        idx = find_pend(unit);
        if (c.valid) begin
            checks++;
            assert (idx >= 0) else begin
                $display("ERROR: %s completed at cycle %0d with nothing outstanding", name, cyc);
                errors++;
            end
            if (idx >= 0) begin
                e = pend_q[idx];
                pend_q.delete(idx);
                assert (unit == FU_DIV || e.cyc == cyc) else begin
                    $display("ERROR: %s completed at cycle %0d instead of cycle %0d",
                             name, cyc, e.cyc);
                    errors++;
                end
                assert (c.rd == e.rd) else begin
                    $display("MISMATCH %s.rd expected %h actual %h", name, e.rd, c.rd);
                    errors++;
                end
                assert (c.value == e.value) else begin
                    $display("MISMATCH %s.value expected %h actual %h", name, e.value, c.value);
                    errors++;
                end
                if (e.rd != '0) begin
                    model[e.rd] = e.value;
                end
            end
        end else if (idx >= 0) begin
            e = pend_q[idx];
            late = (unit != FU_DIV) ? (e.cyc <= cyc) : (cyc - e.cyc > DIV_WINDOW);
            assert (!late) else begin
                $display("ERROR: %s result for tag %0d never arrived", name, e.rd);
                errors++;
            end
            if (late) begin
                pend_q.delete(idx);
            end
        end
    endtask

    task automatic check_outputs();
        logic busy_exp;
        check_unit("cmpl_alu", FU_ALU, cmpl_alu);
        check_unit("cmpl_mul", FU_MUL, cmpl_mul);
        check_unit("cmpl_div", FU_DIV, cmpl_div);
        if (cmpl_alu.valid && cmpl_mul.valid && cmpl_div.valid) begin
            triple_seen = 1'b1;
        end
        // busy until the completion pulse
        busy_exp = (find_pend(FU_DIV) >= 0);
        assert (div_busy == busy_exp) else begin
            $display("MISMATCH div_busy expected %h actual %h", busy_exp, div_busy);
            errors++;
        end
    endtask

    // sample at the falling edge, then drive the next packet
    task automatic step(issue_pkt_t p);
        pend_t e;
        @(negedge clk);
        check_outputs();
        if (p.valid) begin
            e.unit  = p.fu;
            e.rd    = p.rd;
            e.value = expected_value(p);
            e.cyc   = (p.fu == FU_MUL) ? cyc + 1 + MUL_STAGES : cyc + 1;
            pend_q.push_back(e);
        end
        issue = p;
    endtask

    initial begin
        @(posedge clk);
        while (cyc < cycle_limit) begin
            @(posedge clk);
        end
        errors++;
        $display("ERROR: run did not finish within %0d cycles", cycle_limit);
        $display("checks: %0d errors: %0d", checks, errors);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        int unsigned seed;
        int unsigned total;
        int unsigned n_div;
        issue = '0;
        rst   = 1'b1;
        // every register reads zero after reset
        for (int r = 0; r < 64; r++) begin
            model[r] = '0;
        end
        seed  = 32'ha532fa67;
        void'($urandom(seed));
        build_table();
        total = 0;
        n_div = 0;
        for (int i = 0; i < stim_q.size(); i++) begin
            total += 1 + stim_q[i].gap;
            if (stim_q[i].pkt.fu == FU_DIV) begin
                n_div++;
            end
        end
        cycle_limit = total + n_div * DIV_WINDOW + 100;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        assert (!cmpl_alu.valid && !cmpl_mul.valid && !cmpl_div.valid && !div_busy) else begin
            $display("ERROR: completion valid or div_busy high right after reset");
            errors++;
        end
        for (int i = 0; i < stim_q.size(); i++) begin
            if (stim_q[i].pkt.fu == FU_DIV) begin
                while (find_pend(FU_DIV) >= 0 || div_busy) begin
                    step('0);
                end
            end
            step(stim_q[i].pkt);
            repeat (stim_q[i].gap) step('0);
        end
        while (pend_q.size() > 0) begin
            step('0);
        end
        repeat (3) step('0);
        assert (triple_seen) else begin
            $display("ERROR: ALU, mul and div never completed in the same cycle");
            errors++;
        end
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* vlog.f */
rv32i_types.sv
issue_router.sv
phys_regfile.sv
alu_unit.sv
mul_unit.sv
div_unit.sv
writeback_stage.sv
exec_backend_top.sv
tb_exec_backend.sv
